/* fc_pkg.sv */
`default_nettype none

package fc_pkg;

  // ==================================================
  // Memory bus geometry
  // ==================================================
  localparam int ADDR_WIDTH    = 19;
  localparam int MEM_BUS_BYTES = 32;
  // Size field wide enough for a full 32-byte burst
  localparam int SIZE_WIDTH    = 6;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [SIZE_WIDTH-1:0] size_t;

  // ==================================================
  // Chunk and row geometry
  // ==================================================
  localparam int CHUNK_BYTES     = 32;
  localparam int CHUNKS_PER_ROW  = 4;
  localparam int ROW_BYTES       = CHUNK_BYTES * CHUNKS_PER_ROW;
  localparam int CHUNK_IDX_WIDTH = $clog2(CHUNKS_PER_ROW);
  localparam int ROW_CNT_WIDTH   = 8;

  typedef logic [CHUNK_IDX_WIDTH-1:0] chunk_idx_t;
  typedef logic [ROW_CNT_WIDTH-1:0]   row_cnt_t;

  // Payloads, one byte per lane
  typedef logic [CHUNK_BYTES*8-1:0] vec_t;
  typedef logic signed [31:0]       bias_t;
  typedef logic signed [31:0]       acc_t;
  typedef logic [7:0]               out_byte_t;

  // Activation scaling, total right shift after bias add
  localparam int WB_LOG2_SCALE    = 7;
  localparam int LOG2_RELU_FACTOR = 1;
  localparam int LOG2_SCALE       = WB_LOG2_SCALE + LOG2_RELU_FACTOR;

  // ==================================================
  // Memory port structs
  // ==================================================
  typedef struct packed {
    logic  req;
    addr_t addr;
    size_t size;
  } rd_req_t;

  typedef struct packed {
    logic                     valid;
    logic [MEM_BUS_BYTES*8-1:0] data;
  } rd_rsp_t;

  typedef struct packed {
    logic      req;
    addr_t     addr;
    size_t     size;
    out_byte_t data;
  } wr_req_t;

  // Stage payloads
  typedef struct packed {
    logic  valid;
    logic  last;
    vec_t  data;
    vec_t  wgt;
    bias_t bias;
  } chunk_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    acc_t  sum;
    bias_t bias;
  } dp_t;

  typedef struct packed {
    logic      valid;
    out_byte_t data;
  } res_t;

endpackage

`default_nettype wire

/* fc_read_port.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_read_port
  import fc_pkg::*;
#(
  parameter type payload_t = vec_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     fetch,
  input  addr_t    base,
  output rd_req_t  req,
  input  rd_rsp_t  rsp,
  output payload_t payload,
  output logic     ready,
  input  logic     consume
);

  logic req_q;
  logic hit;

  // Response accepted only while our request is up
  assign hit = req_q && rsp.valid;

  // Request level, held until the valid strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q <= 1'b0;
      ready <= 1'b0;
    end
    else
    begin
      if (hit)
        req_q <= 1'b0;
      else if (fetch && !req_q)
        req_q <= 1'b1;
      // Payload held until fetch takes it
      if (hit)
        ready <= 1'b1;
      else if (consume)
        ready <= 1'b0;
    end
  end

  // Low bytes of the bus carry the payload
  always_ff @(posedge clk)
  begin
    if (hit)
      payload <= payload_t'(rsp.data[$bits(payload_t)-1:0]);
  end

  // Address and size read as zero when idle
  assign req.req  = req_q;
  assign req.addr = req_q ? base : '0;
  assign req.size = req_q ? size_t'($bits(payload_t) / 8) : '0;

endmodule

`default_nettype wire

/* fc_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_fetch
  import fc_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    go,
  input  addr_t   addr_x,
  input  addr_t   addr_y,
  input  addr_t   addr_b,
  output rd_req_t data_req,
  output rd_req_t wgt_req,
  output rd_req_t bias_req,
  input  rd_rsp_t data_rsp,
  input  rd_rsp_t wgt_rsp,
  input  rd_rsp_t bias_rsp,
  input  logic    row_done,
  input  logic    layer_done,
  output chunk_t  chunk,
  output logic    busy
);

  chunk_idx_t chunk_idx;
  row_cnt_t   row_idx;
  logic       start, next_row, last_chunk, emit;
  logic       fetch_vec, fetch_bias;
  addr_t      data_base, wgt_base, bias_base;
  vec_t       data_pl, wgt_pl;
  bias_t      bias_pl;
  logic       data_rdy, wgt_rdy, bias_rdy;
  logic       chunk_valid, chunk_last;
  vec_t       chunk_data, chunk_wgt;
  bias_t      chunk_bias;

  // ==================================================
  // Sequencing
  // ==================================================
  // go ignored while a layer runs
  assign start      = go && !busy;
  assign next_row   = row_done && !layer_done;
  assign last_chunk = (chunk_idx == chunk_idx_t'(CHUNKS_PER_ROW - 1));
  // Bias needed only for the first chunk of a row
  assign emit       = data_rdy && wgt_rdy && (bias_rdy || chunk_idx != '0);
  // After the last chunk, stall until writeback frees the row
  assign fetch_vec  = start || next_row || (emit && !last_chunk);
  assign fetch_bias = start || next_row;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy      <= 1'b0;
      chunk_idx <= '0;
      row_idx   <= '0;
    end
    else if (start)
    begin
      busy      <= 1'b1;
      chunk_idx <= '0;
      row_idx   <= '0;
    end
    else
    begin
      if (layer_done)
        busy <= 1'b0;
      if (next_row)
        row_idx <= row_idx + 1'b1;
      // Wraps to zero after the last chunk
      if (emit)
        chunk_idx <= chunk_idx + 1'b1;
    end
  end

  // Addresses follow the indices, stable while a request is held
  assign data_base = addr_x + addr_t'(chunk_idx * CHUNK_BYTES);
  assign wgt_base  = addr_y + addr_t'(row_idx * ROW_BYTES + chunk_idx * CHUNK_BYTES);
  assign bias_base = addr_b + addr_t'(row_idx * ($bits(bias_t) / 8));

  // ==================================================
  // Read clients
  // ==================================================
  fc_read_port #(.payload_t(vec_t)) data_port_i (
    .clk(clk), .rst_n(rst_n), .fetch(fetch_vec), .base(data_base),
    .req(data_req), .rsp(data_rsp), .payload(data_pl),
    .ready(data_rdy), .consume(emit)
  );

  fc_read_port #(.payload_t(vec_t)) wgt_port_i (
    .clk(clk), .rst_n(rst_n), .fetch(fetch_vec), .base(wgt_base),
    .req(wgt_req), .rsp(wgt_rsp), .payload(wgt_pl),
    .ready(wgt_rdy), .consume(emit)
  );

  // Bias payload stays put for the rest of the row
  fc_read_port #(.payload_t(bias_t)) bias_port_i (
    .clk(clk), .rst_n(rst_n), .fetch(fetch_bias), .base(bias_base),
    .req(bias_req), .rsp(bias_rsp), .payload(bias_pl),
    .ready(bias_rdy), .consume(emit && chunk_idx == '0)
  );

  // Chunk register towards the dot product
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      chunk_valid <= 1'b0;
    else
      chunk_valid <= emit;
  end

  always_ff @(posedge clk)
  begin
    if (emit)
    begin
      chunk_last <= last_chunk;
      chunk_data <= data_pl;
      chunk_wgt  <= wgt_pl;
      chunk_bias <= bias_pl;
    end
  end

  assign chunk = '{valid: chunk_valid, last: chunk_last, data: chunk_data,
                   wgt: chunk_wgt, bias: chunk_bias};

endmodule

`default_nettype wire

/* fc_dot_product.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_dot_product
  import fc_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  chunk_t chunk,
  output dp_t    dp
);

  acc_t  sum;
  logic  valid_q, last_q;
  acc_t  sum_q;
  bias_t bias_q;

  // Unsigned data byte times signed weight byte, per lane
  always_comb
  begin
    sum = '0;
    for (int i = 0; i < CHUNK_BYTES; i++)
    begin
      // Zero-extend data to keep it positive
      sum = sum + acc_t'($signed({1'b0, chunk.data[8*i +: 8]}) *
                         $signed(chunk.wgt[8*i +: 8]));
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else
      valid_q <= chunk.valid;
  end

  // Sideband rides along with the partial sum
  always_ff @(posedge clk)
  begin
    if (chunk.valid)
    begin
      last_q <= chunk.last;
      sum_q  <= sum;
      bias_q <= chunk.bias;
    end
  end

  assign dp = '{valid: valid_q, last: last_q, sum: sum_q, bias: bias_q};

endmodule

`default_nettype wire

/* fc_accumulate.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_accumulate
  import fc_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  dp_t  dp,
  output res_t res
);

  acc_t      row_sum;
  acc_t      total;
  acc_t      shifted;
  out_byte_t act;
  logic      res_valid;
  out_byte_t res_data;

  // ==================================================
  // Activation
  // ==================================================
  // Row sum so far, this chunk and the bias
  assign total   = row_sum + dp.sum + dp.bias;
  assign shifted = total >>> LOG2_SCALE;

  always_comb
  begin
    if (total <= 0)
      act = '0;
    // Saturate anything above one byte
    else if (|shifted[$bits(acc_t)-1:$bits(out_byte_t)])
      act = '1;
    else
      act = shifted[$bits(out_byte_t)-1:0];
  end

  // Running sum, cleared at the row end
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_sum   <= '0;
      res_valid <= 1'b0;
    end
    else
    begin
      res_valid <= dp.valid && dp.last;
      if (dp.valid)
        row_sum <= dp.last ? '0 : row_sum + dp.sum;
    end
  end

  always_ff @(posedge clk)
  begin
    if (dp.valid && dp.last)
      res_data <= act;
  end

  assign res = '{valid: res_valid, data: res_data};

endmodule

`default_nettype wire

/* fc_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_writeback
  import fc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  addr_t    addr_z,
  input  row_cnt_t num_rows,
  input  res_t     res,
  output wr_req_t  wr_req,
  input  logic     wr_ack,
  output logic     row_done,
  output logic     layer_done
);

  logic      req_q;
  row_cnt_t  row_idx;
  out_byte_t data_q;
  logic      acked;
  logic      last_row;

  assign acked    = req_q && wr_ack;
  assign last_row = (row_idx == num_rows - 1'b1);

  // Write request held until ack, then row bookkeeping
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q      <= 1'b0;
      row_idx    <= '0;
      row_done   <= 1'b0;
      layer_done <= 1'b0;
    end
    else
    begin
      if (acked)
        req_q <= 1'b0;
      else if (res.valid)
        req_q <= 1'b1;
      row_done   <= acked;
      layer_done <= acked && last_row;
      // Row index back to zero for the next layer
      if (acked)
        row_idx <= last_row ? '0 : row_idx + 1'b1;
    end
  end

  // Result byte, one pending at most
  always_ff @(posedge clk)
  begin
    if (res.valid)
      data_q <= res.data;
  end

  // Fields zero while idle
  assign wr_req.req  = req_q;
  assign wr_req.addr = req_q ? addr_z + addr_t'(row_idx) : '0;
  assign wr_req.size = req_q ? size_t'(1) : '0;
  assign wr_req.data = req_q ? data_q : '0;

endmodule

`default_nettype wire

/* fc_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_layer
  import fc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     go,
  input  addr_t    addr_x,
  input  addr_t    addr_y,
  input  addr_t    addr_b,
  input  addr_t    addr_z,
  input  row_cnt_t num_rows,
  output rd_req_t  data_req,
  output rd_req_t  wgt_req,
  output rd_req_t  bias_req,
  input  rd_rsp_t  data_rsp,
  input  rd_rsp_t  wgt_rsp,
  input  rd_rsp_t  bias_rsp,
  output wr_req_t  wr_req,
  input  logic     wr_ack,
  output logic     busy,
  output logic     done
);

  chunk_t chunk;
  dp_t    dp;
  res_t   res;
  logic   row_done;
  logic   layer_done;

  // ==================================================
  // Fetch, dot product, activate, writeback
  // ==================================================
  fc_fetch fetch_i (
    .clk(clk), .rst_n(rst_n), .go(go),
    .addr_x(addr_x), .addr_y(addr_y), .addr_b(addr_b),
    .data_req(data_req), .wgt_req(wgt_req), .bias_req(bias_req),
    .data_rsp(data_rsp), .wgt_rsp(wgt_rsp), .bias_rsp(bias_rsp),
    .row_done(row_done), .layer_done(layer_done),
    .chunk(chunk), .busy(busy)
  );

  fc_dot_product dot_product_i (
    .clk(clk), .rst_n(rst_n), .chunk(chunk), .dp(dp)
  );

  fc_accumulate accumulate_i (
    .clk(clk), .rst_n(rst_n), .dp(dp), .res(res)
  );

  // Row completion feeds back into fetch
  fc_writeback writeback_i (
    .clk(clk), .rst_n(rst_n), .addr_z(addr_z), .num_rows(num_rows),
    .res(res), .wr_req(wr_req), .wr_ack(wr_ack),
    .row_done(row_done), .layer_done(layer_done)
  );

  assign done = layer_done;

endmodule

`default_nettype wire

/* fc_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fc_layer_tb
  import fc_pkg::*;
;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     go;
  addr_t    addr_x, addr_y, addr_b, addr_z;
  row_cnt_t num_rows;
  rd_req_t  data_req, wgt_req, bias_req;
  rd_rsp_t  rsp_q [3] = '{default: '0};
  wr_req_t  wr_req;
  logic     wr_ack = 1'b0;
  logic     busy, done;

  // Memory image and trace contents
  logic [7:0] mem [int];
  out_byte_t  exp_byte [int];
  addr_t      cfg_x, cfg_y, cfg_b, cfg_z;
  int         cfg_rows;

  // Memory model bookkeeping
  string      port_name [3] = '{"data_req", "wgt_req", "bias_req"};
  int         lat [3];
  bit         active [3];
  bit         shown [3];
  rd_req_t    held [3];
  int         nreq [3];
  int         wr_lat, nwr, wr_total;
  bit         wr_active, ack_shown;
  wr_req_t    wr_held;

  always #20 clk = ~clk;

  fc_layer fc_layer_i (
    .clk(clk), .rst_n(rst_n), .go(go),
    .addr_x(addr_x), .addr_y(addr_y), .addr_b(addr_b), .addr_z(addr_z),
    .num_rows(num_rows),
    .data_req(data_req), .wgt_req(wgt_req), .bias_req(bias_req),
    .data_rsp(rsp_q[0]), .wgt_rsp(rsp_q[1]), .bias_rsp(rsp_q[2]),
    .wr_req(wr_req), .wr_ack(wr_ack), .busy(busy), .done(done)
  );

  // ==================================================
  // Checks
  // ==================================================
  task automatic stop_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_rd_req(string name, rd_req_t got, rd_req_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %0b/%h/%0d expected %0b/%h/%0d", $time, name,
               got.req, got.addr, got.size, exp.req, exp.addr, exp.size);
      stop_run();
    end
  endtask

  task automatic check_wr_req(string name, wr_req_t got, wr_req_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %0b/%h/%0d/%h expected %0b/%h/%0d/%h", $time, name,
               got.req, got.addr, got.size, got.data,
               exp.req, exp.addr, exp.size, exp.data);
      stop_run();
    end
  endtask

  task automatic check_byte(string name, out_byte_t got, out_byte_t exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ==================================================
  // Memory image helpers
  // ==================================================
  // Unloaded bytes mix every address bit
  function automatic logic [7:0] rd_byte(int a);
    if (mem.exists(a))
      return mem[a];
    return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
  endfunction

  function automatic logic [255:0] mem_word(int a);
    logic [255:0] w;
    for (int i = 0; i < 32; i++)
      w[8*i +: 8] = rd_byte(a + i);
    return w;
  endfunction

  // Reference row result from dot product, bias, shift and clamp
  function automatic out_byte_t calc_row(int r);
    longint s;
    longint v;
    s = longint'($signed({rd_byte(cfg_b + 4*r + 3), rd_byte(cfg_b + 4*r + 2),
                          rd_byte(cfg_b + 4*r + 1), rd_byte(cfg_b + 4*r)}));
    for (int j = 0; j < 128; j++)
      s += longint'(rd_byte(cfg_x + j)) * longint'($signed(rd_byte(cfg_y + 128*r + j)));
    if (s <= 0)
      return 8'h00;
    v = s >>> 8;
    return (v > 255) ? 8'hff : out_byte_t'(v);
  endfunction

  // Expected n-th request of port p in the layer
  function automatic rd_req_t expected_rd(int p, int n);
    rd_req_t e;
    e.req = 1'b1;
    if (p == 2)
    begin
      e.addr = cfg_b + addr_t'(4*n);
      e.size = 6'd4;
    end
    else
    begin
      e.addr = (p == 0) ? cfg_x + addr_t'(32*(n % 4))
                        : cfg_y + addr_t'(128*(n / 4) + 32*(n % 4));
      e.size = 6'd32;
    end
    return e;
  endfunction

  task automatic load_trace();
    int fd;
    string line;
    logic [31:0] a, b, c, d, e;
    logic [255:0] w;
    fd = $fopen("fc_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file fc_trace.txt");
      stop_run();
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() < 2)
        continue;
      if (line.getc(0) == "C" && $sscanf(line, "C %h %h %h %h %d", a, b, c, d, e) == 5)
      begin
        cfg_x = addr_t'(a);
        cfg_y = addr_t'(b);
        cfg_b = addr_t'(c);
        cfg_z = addr_t'(d);
        cfg_rows = int'(e);
      end
      else if (line.getc(0) == "M" && $sscanf(line, "M %h %h", a, w) == 2)
      begin
        for (int i = 0; i < 32; i++)
          mem[int'(a) + i] = w[8*i +: 8];
      end
      else if (line.getc(0) == "E" && $sscanf(line, "E %d %h", a, b) == 2)
        exp_byte[int'(a)] = out_byte_t'(b);
    end
    $fclose(fd);
  endtask

  // ==================================================
  // Memory model sampling and driving 1 ns after the edge
  // ==================================================
  always @(posedge clk)
  begin
    rd_req_t rq [3];
    rd_req_t e;
    #1;
    rq[0] = data_req;
    rq[1] = wgt_req;
    rq[2] = bias_req;
    for (int p = 0; p < 3; p++)
    begin
      if (shown[p])
      begin
        // Request and its fields must drop right after the strobe
        check_rd_req(port_name[p], rq[p], '0);
        shown[p] = 0;
        active[p] = 0;
        rsp_q[p] = '0;
      end
      else if (rq[p].req || active[p])
      begin
        if (!active[p])
        begin
          active[p] = 1;
          lat[p] = $urandom % 6;
          e = expected_rd(p, nreq[p]);
          check_rd_req(port_name[p], rq[p], e);
          // Next row only after this row's write ack
          if (p < 2 && nreq[p] / 4 > nwr)
          begin
            $display("Read for row %0d issued before the previous write was acknowledged",
                     nreq[p] / 4);
            stop_run();
          end
          held[p] = rq[p];
          nreq[p]++;
        end
        else
          check_rd_req(port_name[p], rq[p], held[p]);
        if (lat[p] == 0)
        begin
          rsp_q[p] = '{valid: 1'b1, data: mem_word(int'(rq[p].addr))};
          shown[p] = 1;
        end
        else
          lat[p]--;
      end
      else
        // Idle port shows all fields zero
        check_rd_req(port_name[p], rq[p], '0);
    end
    // Write port
    if (ack_shown)
    begin
      check_wr_req("wr_req", wr_req, '0);
      ack_shown = 0;
      wr_active = 0;
      wr_ack = 1'b0;
    end
    else if (wr_req.req || wr_active)
    begin
      if (!wr_active)
      begin
        wr_active = 1;
        wr_lat = $urandom % 6;
        wr_held = '{req: 1'b1, addr: cfg_z + addr_t'(nwr), size: 6'd1, data: exp_byte[nwr]};
      end
      check_wr_req("wr_req", wr_req, wr_held);
      if (wr_lat == 0)
      begin
        wr_ack = 1'b1;
        ack_shown = 1;
        nwr++;
        wr_total++;
      end
      else
        wr_lat--;
    end
    else
      check_wr_req("wr_req", wr_req, '0);
    // Layer end needs all rows acked
    if (done === 1'b1)
    begin
      if (nwr != cfg_rows)
      begin
        $display("Done raised after %0d of %0d row writes", nwr, cfg_rows);
        stop_run();
      end
      nreq = '{default: 0};
      nwr = 0;
    end
  end

  // ==================================================
  // Layer runs
  // ==================================================
  task automatic run_layer(int pass);
    int cycles;
    go = 1'b1;
    @(posedge clk);
    #1;
    go = 1'b0;
    check_bit("busy", busy, 1'b1);
    check_bit("data_req.req", data_req.req, 1'b1);
    check_bit("wgt_req.req", wgt_req.req, 1'b1);
    cycles = 0;
    while (done !== 1'b1)
    begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > 4000)
      begin
        $display("Timed out waiting for done on layer run %0d", pass);
        stop_run();
      end
    end
    if (wr_total != cfg_rows * pass)
    begin
      $display("Expected %0d row writes in total but saw %0d", cfg_rows * pass, wr_total);
      stop_run();
    end
    @(posedge clk);
    #1;
    check_bit("done", done, 1'b0);
    check_bit("busy", busy, 1'b0);
    // Quiet ports after the layer
    repeat (5)
    begin
      check_bit("data_req.req", data_req.req, 1'b0);
      check_bit("wgt_req.req", wgt_req.req, 1'b0);
      check_bit("bias_req.req", bias_req.req, 1'b0);
      check_bit("wr_req.req", wr_req.req, 1'b0);
      @(posedge clk);
      #1;
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    go = 1'b0;
    addr_x = '0;
    addr_y = '0;
    addr_b = '0;
    addr_z = '0;
    num_rows = '0;
    nreq = '{default: 0};
    void'($urandom(69));
    load_trace();
    // Trace bytes against the reference computation
    for (int r = 0; r < cfg_rows; r++)
      check_byte("trace expected byte", exp_byte[r], calc_row(r));
    addr_x = cfg_x;
    addr_y = cfg_y;
    addr_b = cfg_b;
    addr_z = cfg_z;
    num_rows = row_cnt_t'(cfg_rows);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_bit("data_req.req", data_req.req, 1'b0);
    check_bit("wgt_req.req", wgt_req.req, 1'b0);
    check_bit("bias_req.req", bias_req.req, 1'b0);
    check_bit("wr_req.req", wr_req.req, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    run_layer(1);
    // Same layer again
    run_layer(2);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* fc_trace.txt */
# C addr_x addr_y addr_b addr_z num_rows
# M addr 32-byte word in hex, leftmost byte at addr+31; E row expected_byte
C 01000 02000 03000 04000 3
# Input vector, chunk k holds byte k+1
M 01000 0101010101010101010101010101010101010101010101010101010101010101
M 01020 0202020202020202020202020202020202020202020202020202020202020202
M 01040 0303030303030303030303030303030303030303030303030303030303030303
M 01060 0404040404040404040404040404040404040404040404040404040404040404
# Row 0 weights, all +16
M 02000 1010101010101010101010101010101010101010101010101010101010101010
M 02020 1010101010101010101010101010101010101010101010101010101010101010
M 02040 1010101010101010101010101010101010101010101010101010101010101010
M 02060 1010101010101010101010101010101010101010101010101010101010101010
# Row 1 weights, all -1
M 02080 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
M 020a0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
M 020c0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
M 020e0 ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
# Row 2 weights, all +127
M 02100 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
M 02120 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
M 02140 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
M 02160 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
# Biases 0x40, 0x100, 0x8000
M 03000 0000000000000000000000000000000000000000000080000000010000000040
# Row 0 5184 >> 8, row 1 negative, row 2 clamped
E 0 14
E 1 00
E 2 ff

/* filelist.f */
fc_pkg.sv
fc_read_port.sv
fc_fetch.sv
fc_dot_product.sv
fc_accumulate.sv
fc_writeback.sv
fc_layer.sv
fc_layer_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f filelist.f --top-module fc_layer_tb -o fc_layer_sim

out=$(./obj_dir/fc_layer_sim)
echo "$out"
echo "$out" | grep -q "All checks passed"
